//--- source/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // Data path and bus widths
    typedef logic [63:0] xlen_t;      // Register and bus data
    typedef logic [63:0] addr_t;      // Bus address
    typedef logic [31:0] inst_t;      // Instruction word
    typedef logic [31:0] pc_t;        // Program counter
    typedef logic [4:0]  reg_idx_t;   // x0..x31
    typedef logic [11:0] csr_addr_t;  // 12-bit CSR space
    typedef logic [3:0]  irq_vec_t;   // Interrupt vector from the platform

    // Major opcodes in use
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // Machine CSR addresses
    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MIE     = 12'h304;
    localparam csr_addr_t CSR_MIP     = 12'h344;
    localparam csr_addr_t CSR_MCAUSE  = 12'h342;

    // Memory mapped peripherals
    localparam addr_t KEY_BASE     = 64'h0000_0000_8000_0010;  // Keyboard data
    localparam addr_t DISPLAY_BASE = 64'h0000_0000_8000_0000;  // Display register

    localparam irq_vec_t IRQ_KEYBOARD = 4'd1;

    // Register file write port
    typedef struct packed {
        logic     valid;
        reg_idx_t index;
        xlen_t    data;
    } rf_write_t;

    // CSR access, one per cycle
    typedef struct packed {
        logic      valid;
        csr_addr_t addr;
        xlen_t     wdata;
    } csr_req_t;

    // Memory bus request
    typedef struct packed {
        addr_t addr;
        xlen_t wdata;
        logic  we;    // Write strobe, completes same cycle
        logic  re;    // Read strobe, data one cycle later
    } bus_req_t;

endpackage

`default_nettype wire

//--- source/rv_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module rv_fetch import rv_pkg::*; (
    input  wire   clk,
    input  wire   reset,        // Active low
    input  inst_t instruction,  // Word presented for the current pc
    output pc_t   pc,
    output inst_t ir,
    output logic  heartbeat
);

    // No branches, so the pc just walks forward one word per cycle
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc        <= '0;
            ir        <= '0;  // Decodes as nothing
            heartbeat <= 1'b0;
        end else begin
            pc        <= pc + 32'd4;
            ir        <= instruction;  // Executed in the next cycle
            heartbeat <= ~heartbeat;   // Liveness toggle
        end
    end

endmodule

`default_nettype wire

//--- source/rv_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module rv_regfile import rv_pkg::*; (
    input  wire       clk,
    input  wire       reset,
    input  rf_write_t wr,
    input  reg_idx_t  rs1_index,
    output xlen_t     rs1_data,
    input  reg_idx_t  debug_index,
    output xlen_t     debug_data
);

    xlen_t regs [1:31];  // x0 has no storage

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.valid && wr.index != 5'd0) begin  // Writes to x0 dropped
            regs[wr.index] <= wr.data;
        end
    end

    // Combinational reads, x0 hardwired to zero
    assign rs1_data   = (rs1_index == 5'd0) ? '0 : regs[rs1_index];
    assign debug_data = (debug_index == 5'd0) ? '0 : regs[debug_index];

endmodule

`default_nettype wire

//--- source/rv_execute.sv
`timescale 1ns/10ps
`default_nettype none

module rv_execute import rv_pkg::*; (
    input  inst_t     ir,
    output reg_idx_t  rs1_index,
    input  xlen_t     rs1_data,
    output csr_req_t  csr_req,
    input  xlen_t     csr_rdata,  // Old CSR value, same cycle
    output rf_write_t wr
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_idx_t   rd;
    xlen_t      imm_u;
    xlen_t      imm_i;

    // Field extraction
    assign opcode    = ir[6:0];
    assign rd        = ir[11:7];
    assign funct3    = ir[14:12];
    assign rs1_index = ir[19:15];

    assign imm_u = {{32{ir[31]}}, ir[31:12], 12'b0};  // LUI, sign extended to 64
    assign imm_i = {{52{ir[31]}}, ir[31:20]};         // I-type

    always_comb begin
        wr            = '0;  // Unknown encodings are a no-op
        csr_req       = '0;
        wr.index      = rd;
        csr_req.addr  = ir[31:20];
        csr_req.wdata = rs1_data;  // CSRRW source
        case (opcode)
            OPC_LUI: begin
                wr.valid = 1'b1;
                wr.data  = imm_u;
            end
            OPC_OP_IMM: begin
                if (funct3 == 3'b000) begin  // ADDI only
                    wr.valid = 1'b1;
                    wr.data  = rs1_data + imm_i;
                end
            end
            OPC_SYSTEM: begin
                if (funct3 == 3'b001) begin  // CSRRW
                    csr_req.valid = 1'b1;
                    // Swap: old CSR value goes to rd
                    wr.valid = 1'b1;
                    wr.data  = csr_rdata;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- source/rv_csr.sv
`timescale 1ns/10ps
`default_nettype none

module rv_csr import rv_pkg::*; (
    input  wire      clk,
    input  wire      reset,
    input  csr_req_t req,
    output xlen_t    rdata,
    input  irq_vec_t interrupt_vector,
    input  wire      mover_idle,
    output logic     irq_take
);

    // Bit 63 flags an interrupt, 11 is machine external
    localparam xlen_t MCAUSE_MEI = {1'b1, 59'b0, 4'd11};

    xlen_t mstatus;
    xlen_t mie;
    xlen_t mcause;
    xlen_t mip;
    logic  meip;

    // Pending comes straight from the vector, not software writable
    assign meip = (interrupt_vector == IRQ_KEYBOARD);
    assign mip  = {52'b0, meip, 11'b0};  // MEIP at bit 11

    assign irq_take = meip && mstatus[3] && mie[11] && mover_idle;  // MIE, MEIE

    always_comb begin
        case (req.addr)
            CSR_MSTATUS: rdata = mstatus;
            CSR_MIE:     rdata = mie;
            CSR_MIP:     rdata = mip;
            CSR_MCAUSE:  rdata = mcause;
            default:     rdata = '0;  // Unimplemented CSRs read zero
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mstatus <= '0;
            mie     <= '0;
            mcause  <= '0;
        end else begin
            if (req.valid && req.addr == CSR_MSTATUS) mstatus <= req.wdata;
            if (req.valid && req.addr == CSR_MIE)     mie     <= req.wdata;
            // Interrupt wins over a software write on the same edge
            if (irq_take) begin
                mcause <= MCAUSE_MEI;
            end else if (req.valid && req.addr == CSR_MCAUSE) begin
                mcause <= req.wdata;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/rv_irq_mover.sv
`timescale 1ns/10ps
`default_nettype none

module rv_irq_mover import rv_pkg::*; (
    input  wire      clk,
    input  wire      reset,
    input  wire      irq_take,       // Level, held while pending and enabled
    input  xlen_t    bus_read_data,  // Valid the cycle after the read strobe
    output bus_req_t bus_req,
    output logic     interrupt_done,
    output logic     idle
);

    typedef enum logic [1:0] {
        IDLE,
        READ,
        WRITE
    } mover_state_t;

    mover_state_t state;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (irq_take) state <= READ;
                READ:    state <= WRITE;  // Key data arrives during WRITE
                WRITE:   state <= IDLE;   // Can retrigger if vector still held
                default: state <= IDLE;
            endcase
        end
    end

    // Strobes decoded from the state flops
    always_comb begin
        bus_req = '0;  // Everything low outside a strobe
        case (state)
            READ: begin
                bus_req.addr = KEY_BASE;
                bus_req.re   = 1'b1;
            end
            WRITE: begin
                bus_req.addr  = DISPLAY_BASE;
                bus_req.wdata = {56'b0, bus_read_data[7:0]};  // Key byte only
                bus_req.we    = 1'b1;
            end
            default: ;
        endcase
    end

    assign interrupt_done = (state == WRITE);  // Same cycle as the display write
    assign idle           = (state == IDLE);

endmodule

`default_nettype wire

//--- source/rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core import rv_pkg::*; (
    input  wire      clk,
    input  wire      reset,             // Active low, asynchronous
    input  inst_t    instruction,
    input  irq_vec_t interrupt_vector,
    output pc_t      pc,
    output logic     heartbeat,
    output bus_req_t bus_req,
    input  xlen_t    bus_read_data,
    output logic     interrupt_done,
    input  reg_idx_t debug_index,
    output xlen_t    debug_data
);

    inst_t     ir;
    rf_write_t rf_wr;
    reg_idx_t  rs1_index;
    xlen_t     rs1_data;
    csr_req_t  csr_req;
    xlen_t     csr_rdata;
    logic      irq_take;
    logic      mover_idle;

    rv_fetch fetch_i (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .pc          (pc),
        .ir          (ir),
        .heartbeat   (heartbeat)
    );

    // Single cycle execute behind the ir
    rv_execute execute_i (
        .ir        (ir),
        .rs1_index (rs1_index),
        .rs1_data  (rs1_data),
        .csr_req   (csr_req),
        .csr_rdata (csr_rdata),
        .wr        (rf_wr)
    );

    rv_regfile regfile_i (
        .clk         (clk),
        .reset       (reset),
        .wr          (rf_wr),
        .rs1_index   (rs1_index),
        .rs1_data    (rs1_data),
        .debug_index (debug_index),
        .debug_data  (debug_data)
    );

    rv_csr csr_i (
        .clk              (clk),
        .reset            (reset),
        .req              (csr_req),
        .rdata            (csr_rdata),
        .interrupt_vector (interrupt_vector),
        .mover_idle       (mover_idle),
        .irq_take         (irq_take)
    );

    // Hardware keyboard service, sole bus master
    rv_irq_mover irq_mover_i (
        .clk            (clk),
        .reset          (reset),
        .irq_take       (irq_take),
        .bus_read_data  (bus_read_data),
        .bus_req        (bus_req),
        .interrupt_done (interrupt_done),
        .idle           (mover_idle)
    );

endmodule

`default_nettype wire

//--- test/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset  // Active low
);

    localparam int HALF_PERIOD = 4;  // 8 ns clock

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Held low for two rising edges, released on an edge
    initial begin
        reset = 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b1;
    end

endmodule

`default_nettype wire

//--- test/tb_checker.sv
`timescale 1ns/10ps
`default_nettype none

module tb_checker import rv_pkg::*; (
    input  wire         clk,
    input  wire         reset,
    input  pc_t         pc,
    input  wire         heartbeat,
    input  bus_req_t    bus_req,
    input  xlen_t       bus_read_data,  // Key returned by the bus model
    input  wire         interrupt_done,
    input  xlen_t       debug_data,
    input  wire         test_end,       // One cycle strobe at the end of a record
    input  wire [127:0] test_name,
    input  xlen_t       exp_data,
    input  wire [31:0]  exp_irqs,
    output int          tests_run,
    output int          tests_failed,
    output int          errors
);

    int   n_run = 0;
    int   n_failed = 0;
    int   n_errors = 0;
    int   test_errors = 0;
    int   irq_count = 0;   // Display writes seen in the running record
    pc_t  exp_pc;
    logic exp_hb;
    logic prev_re;         // Read strobe one cycle back

    assign tests_run    = n_run;
    assign tests_failed = n_failed;
    assign errors       = n_errors;

    task automatic flag_error(input string msg);
        $display("error %0t: %0s", $time, msg);
        test_errors++;
        n_errors++;
    endtask

    // Register and interrupt count compare, then the per-record line
    task automatic close_test();
        if (debug_data !== exp_data)
            flag_error($sformatf("debug data %h, expected %h", debug_data, exp_data));
        if (irq_count != exp_irqs)
            flag_error($sformatf("%0d interrupts serviced, expected %0d", irq_count, exp_irqs));
        n_run++;
        if (test_errors == 0) begin
            $display("test %0s: ok", test_name);
        end else begin
            n_failed++;
            $display("test %0s: failed with %0d errors", test_name, test_errors);
        end
        test_errors = 0;
        irq_count   = 0;
    endtask

    // Sampled on the falling edge half a cycle after the driver
    always @(negedge clk) begin
        if (!reset) begin
            if (pc !== '0 || heartbeat !== 1'b0)
                flag_error($sformatf("pc %h heartbeat %b in reset", pc, heartbeat));
            exp_pc  = '0;
            exp_hb  = 1'b0;
            prev_re = 1'b0;
        end else begin
            if (pc !== exp_pc)
                flag_error($sformatf("pc %h, expected %h", pc, exp_pc));
            if (heartbeat !== exp_hb)
                flag_error($sformatf("heartbeat %b, expected %b", heartbeat, exp_hb));
            exp_pc = exp_pc + 32'd4;  // One word per cycle
            exp_hb = ~exp_hb;
            if (bus_req.re && (bus_req.addr !== KEY_BASE || bus_req.wdata !== '0 ||
                               bus_req.we || interrupt_done))
                flag_error($sformatf("read strobe at %h, not a clean keyboard read", bus_req.addr));
            if (prev_re && !bus_req.we)
                flag_error("key read not followed by a display write");
            if (bus_req.we) begin
                irq_count++;
                if (!prev_re)
                    flag_error("display write without a key read one cycle before");
                if (bus_req.addr !== DISPLAY_BASE)
                    flag_error($sformatf("write address %h, expected %h", bus_req.addr,
                                         DISPLAY_BASE));
                if (bus_req.wdata !== {56'b0, bus_read_data[7:0]})  // Key byte only
                    flag_error($sformatf("display data %h, expected %h", bus_req.wdata,
                                         {56'b0, bus_read_data[7:0]}));
                if (interrupt_done !== 1'b1)
                    flag_error("interrupt_done low during the display write");
            end else if (interrupt_done !== 1'b0) begin
                flag_error("interrupt_done high without a display write");
            end
            if (!bus_req.re && !bus_req.we && bus_req !== '0)
                flag_error("bus address or data not zero between strobes");
            prev_re = bus_req.re;
            if (test_end) close_test();
        end
    end

endmodule

`default_nettype wire

//--- test/tb_rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core import rv_pkg::*; ();

    localparam int MAX_TESTS = 32;
    localparam int DRAIN     = 4;  // Cycles for the mover to finish after the vector drops

    logic     clk;
    logic     reset;
    inst_t    instruction      = '0;
    irq_vec_t interrupt_vector = '0;
    xlen_t    bus_read_data    = '0;
    reg_idx_t debug_index      = '0;
    pc_t      pc;
    logic     heartbeat;
    bus_req_t bus_req;
    logic     interrupt_done;
    xlen_t    debug_data;

    // Records from the data file
    logic [127:0] names      [MAX_TESTS];
    inst_t        instrs     [MAX_TESTS][4];
    irq_vec_t     vecs       [MAX_TESTS];
    xlen_t        keys       [MAX_TESTS];
    reg_idx_t     dbg_regs   [MAX_TESTS];
    xlen_t        exp_regs   [MAX_TESTS];
    logic [31:0]  exp_counts [MAX_TESTS];
    int           holds      [MAX_TESTS];
    int           n_tests     = 0;
    int           load_errors = 0;
    int           timeout_ns  = 0;
    logic         loaded      = 1'b0;

    xlen_t        key_value = '0;         // Zero selects a random key
    logic [31:0]  lcg_state = 32'h3cbc;
    logic         test_end  = 1'b0;
    logic [127:0] test_name = '0;
    xlen_t        exp_data  = '0;
    logic [31:0]  exp_irqs  = '0;
    int           tests_run;
    int           tests_failed;
    int           errors;

    tb_clock clock_i (.clk(clk), .reset(reset));

    rv_core rv_core_i (
        .clk              (clk),
        .reset            (reset),
        .instruction      (instruction),
        .interrupt_vector (interrupt_vector),
        .pc               (pc),
        .heartbeat        (heartbeat),
        .bus_req          (bus_req),
        .bus_read_data    (bus_read_data),
        .interrupt_done   (interrupt_done),
        .debug_index      (debug_index),
        .debug_data       (debug_data)
    );

    tb_checker checker_i (
        .clk            (clk),
        .reset          (reset),
        .pc             (pc),
        .heartbeat      (heartbeat),
        .bus_req        (bus_req),
        .bus_read_data  (bus_read_data),
        .interrupt_done (interrupt_done),
        .debug_data     (debug_data),
        .test_end       (test_end),
        .test_name      (test_name),
        .exp_data       (exp_data),
        .exp_irqs       (exp_irqs),
        .tests_run      (tests_run),
        .tests_failed   (tests_failed),
        .errors         (errors)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Bus model answers one cycle after the read strobe
    always @(posedge clk) begin
        if (reset && bus_req.re) begin
            if (key_value != '0) begin
                bus_read_data <= key_value;
            end else begin
                lcg_state     <= lcg_next(lcg_state);
                bus_read_data <= {32'b0, lcg_next(lcg_state)};
            end
        end
    end

    // Four instruction slots and the extra cycles, then drain and the end strobe
    task automatic apply_record(input int t);
        for (int c = 0; c < 4 + holds[t]; c++) begin
            @(posedge clk);
            instruction      <= (c < 4) ? instrs[t][c] : '0;
            interrupt_vector <= vecs[t];  // Held for the whole record
            key_value        <= keys[t];
        end
        @(posedge clk);
        instruction      <= '0;
        interrupt_vector <= '0;
        debug_index      <= dbg_regs[t];
        repeat (DRAIN) @(posedge clk);
        test_name <= names[t];
        exp_data  <= exp_regs[t];
        exp_irqs  <= exp_counts[t];
        test_end  <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
    endtask

    initial begin : run
        int               fd;
        int               code;
        int               line_no;
        int               total_cycles;
        logic [8*256-1:0] line;
        logic [127:0]     nm;
        inst_t            i0;
        inst_t            i1;
        inst_t            i2;
        inst_t            i3;
        irq_vec_t         v;
        xlen_t            k;
        xlen_t            e;
        int               d;
        int               c;
        int               h;
        line_no      = 0;
        total_cycles = 0;
        fd = $fopen("test/rv_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/rv_input.txt");
            $display("** FAIL **");
            $finish;
        end else begin
            while ($fgets(line, fd) != 0) begin
                line_no++;
                code = $sscanf(line, "%s %h %h %h %h %h %h %d %h %d %d",
                               nm, i0, i1, i2, i3, v, k, d, e, c, h);
                if (code == 11 && n_tests < MAX_TESTS) begin
                    names[n_tests]      = nm;
                    instrs[n_tests][0]  = i0;
                    instrs[n_tests][1]  = i1;
                    instrs[n_tests][2]  = i2;
                    instrs[n_tests][3]  = i3;
                    vecs[n_tests]       = v;
                    keys[n_tests]       = k;
                    dbg_regs[n_tests]   = d[4:0];
                    exp_regs[n_tests]   = e;
                    exp_counts[n_tests] = c;
                    holds[n_tests]      = h;
                    total_cycles += 4 + h + DRAIN + 2;
                    n_tests++;
                end else if (code > 1 || (code == 1 && nm != "#")) begin
                    // Only lines led by a lone hash are comments
                    $display("line %0d of test/rv_input.txt is not a usable record", line_no);
                    load_errors++;
                end
            end
            $fclose(fd);
            timeout_ns = (total_cycles + 40) * 8;  // Reset and margin included
            loaded     = 1'b1;
            wait (reset === 1'b1);
            for (int t = 0; t < n_tests; t++) apply_record(t);
            @(posedge clk);
            $display("%0d tests run, %0d failed, %0d errors, %0d bad records",
                     tests_run, tests_failed, errors, load_errors);
            if (errors == 0 && tests_failed == 0 && load_errors == 0 &&
                tests_run == n_tests && n_tests > 0) begin
                $display("** PASS **");
            end else begin
                $display("** FAIL **");
            end
            $finish;
        end
    end

    initial begin : watchdog
        wait (loaded === 1'b1);
        #(timeout_ns);
        $display("watchdog expired after %0d ns, the tests did not finish", timeout_ns);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/rv_input.txt
# name  inst0 inst1 inst2 inst3 (hex)  vector  key (0 = random)  reg  expected reg (hex)  irqs  extra
# One instruction slot per cycle, the vector is held for 4 + extra cycles
reset_pc        00000000 00000000 00000000 00000000 0 00 0 0000000000000000 0 2
lui_addi        123450b7 67808113 00508013 800001b7 0 00 2 0000000012345678 0 0
x0_write        00000000 00000000 00000000 00000000 0 00 0 0000000000000000 0 0
lui_sign        00000000 00000000 00000000 00000000 0 00 3 ffffffff80000000 0 0
irq_masked      00000000 00000000 00000000 00000000 1 5a 1 0000000012345000 0 6
irq_enable      00800293 80000313 300293f3 30431473 1 a5 8 0000000000000000 2 6
csr_swap        300294f3 304315f3 34201573 00000000 0 00 9 0000000000000008 0 0
mcause_read     00000000 00000000 00000000 00000000 0 00 10 800000000000000b 0 0
old_mie         00000000 00000000 00000000 00000000 0 00 11 fffffffffffff800 0 0
irq_random      00000000 00000000 00000000 00000000 1 00 5 0000000000000008 4 8
irq_random_long 00000000 00000000 00000000 00000000 1 00 6 fffffffffffff800 6 14

//--- src.f
source/rv_pkg.sv
source/rv_fetch.sv
source/rv_regfile.sv
source/rv_execute.sv
source/rv_csr.sv
source/rv_irq_mover.sv
source/rv_core.sv
test/tb_clock.sv
test/tb_checker.sv
test/tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  # Design, package first
  - source/rv_pkg.sv
  - source/rv_fetch.sv
  - source/rv_regfile.sv
  - source/rv_execute.sv
  - source/rv_csr.sv
  - source/rv_irq_mover.sv
  - source/rv_core.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/tb_checker.sv
      - test/tb_rv_core.sv
